/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := nids_match_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+hdl
hdl/nids_match_pkg.sv
hdl/pkt_beat_if.sv
hdl/stream_ingress.sv
hdl/beat_fifo.sv
hdl/sig_dfa.sv
hdl/stream_context_matcher.sv
hdl/nids_match_top.sv
verification/nids_match_checker.sv
verification/nids_match_tb.sv

/* hdl/beat_fifo.sv */
`include "nids_match_consts.svh"

module beat_fifo #(
  parameter int DEPTH = `NM_FIFO_DEPTH
)
(
  input  logic         clk,
  input  logic         rst_n,
  pkt_beat_if.consumer wr,
  pkt_beat_if.producer rd
);

  localparam int PTR_W  = $clog2(DEPTH);
  localparam int CNT_W  = PTR_W + 1;
  // data, sop, eop, stream id, new stream, enable
  localparam int BEAT_W = 8 + 2 + `NM_STREAM_W + 2;

  logic [BEAT_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              full;
  logic              wr_fire;
  logic              rd_fire;

  assign full = (count == CNT_W'(DEPTH));

  // Write still allowed when full if the head leaves this cycle
  assign wr.ready = !full || rd.ready;
  assign rd.valid = (count != '0);
  assign {rd.data, rd.sop, rd.eop, rd.stream_id, rd.new_stream, rd.enable} = mem[rd_ptr];

  assign wr_fire = wr.valid && wr.ready;
  assign rd_fire = rd.valid && rd.ready;

  // Beat storage
  always_ff @(posedge clk)
  begin
    if (wr_fire)
      mem[wr_ptr] <= {wr.data, wr.sop, wr.eop, wr.stream_id, wr.new_stream, wr.enable};
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_fire)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_fire)
        rd_ptr <= rd_ptr + 1'b1;
      if (wr_fire && !rd_fire)
        count <= count + 1'b1;
      else if (rd_fire && !wr_fire)
        count <= count - 1'b1;
    end
  end

endmodule

/* hdl/nids_match_consts.svh */
`ifndef NIDS_MATCH_CONSTS_SVH
`define NIDS_MATCH_CONSTS_SVH

// Stream id width, 64 interleaved streams
`define NM_STREAM_W 6

// DFA state width, enough for states 0 to 5
`define NM_STATE_W 3

// Running match count width
`define NM_COUNT_W 16

// Default beat FIFO depth, power of two
`define NM_FIFO_DEPTH 8

// Literal signature "GROUP"
`define NM_SIG_LEN 5
`define NM_SIG_0 8'h47
`define NM_SIG_1 8'h52
`define NM_SIG_2 8'h4f
`define NM_SIG_3 8'h55
`define NM_SIG_4 8'h50

`endif

/* hdl/nids_match_pkg.sv */
package nids_match_pkg;

  // Ingress framing state
  // Idle means no packet is open, a sop is expected next
  typedef enum logic
  {
    FR_IDLE   = 1'b0,
    FR_IN_PKT = 1'b1
  } frame_state_e;

  // Context matcher state
  // Idle only right after reset
  // Load waits for a sop beat and reads the saved context
  // Scan consumes beats up to and including eop
  typedef enum logic [1:0]
  {
    CTX_IDLE = 2'd0,
    CTX_LOAD = 2'd1,
    CTX_SCAN = 2'd2
  } ctx_state_e;

endpackage

/* hdl/nids_match_top.sv */
`include "nids_match_consts.svh"

module nids_match_top
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  logic [7:0]              in_data,
  input  logic                    in_sop,
  input  logic                    in_eop,
  input  logic [`NM_STREAM_W-1:0] in_stream_id,
  input  logic                    in_new_stream,
  input  logic                    in_enable,
  output logic                    in_ready,
  output logic                    pkt_done,
  output logic                    pkt_matched,
  output logic [`NM_STREAM_W-1:0] pkt_stream_id,
  output logic [`NM_COUNT_W-1:0]  match_count,
  output logic                    framing_error
);

  // Framer to FIFO, and FIFO head to matcher
  pkt_beat_if ing_to_fifo ();
  pkt_beat_if fifo_to_ctx ();

  stream_ingress stream_ingress_inst
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_data       (in_data),
    .in_sop        (in_sop),
    .in_eop        (in_eop),
    .in_stream_id  (in_stream_id),
    .in_new_stream (in_new_stream),
    .in_enable     (in_enable),
    .in_ready      (in_ready),
    .beat_out      (ing_to_fifo.producer),
    .framing_error (framing_error)
  );

  beat_fifo #(
    .DEPTH (`NM_FIFO_DEPTH)
  ) beat_fifo_inst
  (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (ing_to_fifo.consumer),
    .rd    (fifo_to_ctx.producer)
  );

  stream_context_matcher stream_context_matcher_inst
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .beat_in       (fifo_to_ctx.consumer),
    .pkt_done      (pkt_done),
    .pkt_matched   (pkt_matched),
    .pkt_stream_id (pkt_stream_id),
    .match_count   (match_count)
  );

endmodule

/* hdl/pkt_beat_if.sv */
`include "nids_match_consts.svh"

interface pkt_beat_if;

  // Handshake
  logic                    valid;
  logic                    ready;

  // One byte per beat, with packet framing
  logic [7:0]              data;
  logic                    sop;
  logic                    eop;

  // Packet header, carried on every beat of the packet
  logic [`NM_STREAM_W-1:0] stream_id;
  logic                    new_stream;
  logic                    enable;

  // Source side drives everything but ready
  modport producer (output valid, data, sop, eop, stream_id, new_stream, enable,
                    input ready);

  // Sink side drives only ready
  modport consumer (input valid, data, sop, eop, stream_id, new_stream, enable,
                    output ready);

endinterface

/* hdl/sig_dfa.sv */
`include "nids_match_consts.svh"

module sig_dfa
(
  input  logic [`NM_STATE_W-1:0] state_in,
  input  logic [7:0]             char_in,
  output logic [`NM_STATE_W-1:0] state_out,
  output logic                   accept
);

  // Byte that advances the current state
  logic [7:0] expect_char;

  always_comb
  begin
    case (state_in)
      3'd0:    expect_char = `NM_SIG_0;
      3'd1:    expect_char = `NM_SIG_1;
      3'd2:    expect_char = `NM_SIG_2;
      3'd3:    expect_char = `NM_SIG_3;
      3'd4:    expect_char = `NM_SIG_4;
      // Unreachable states restart on the first byte
      default: expect_char = `NM_SIG_0;
    endcase
  end

  // No self-overlap in the literal, so a miss only checks for a fresh first byte
  always_comb
  begin
    accept    = 1'b0;
    state_out = '0;
    if (char_in == expect_char)
    begin
      // Last byte completes the signature, fall back to state 0
      if (state_in == `NM_STATE_W'(`NM_SIG_LEN - 1))
        accept = 1'b1;
      else
        state_out = state_in + 1'b1;
    end
    else if (char_in == `NM_SIG_0)
    begin
      state_out = `NM_STATE_W'(1);
    end
  end

endmodule

/* hdl/stream_context_matcher.sv */
`include "nids_match_consts.svh"

module stream_context_matcher
  import nids_match_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  pkt_beat_if.consumer            beat_in,
  output logic                    pkt_done,
  output logic                    pkt_matched,
  output logic [`NM_STREAM_W-1:0] pkt_stream_id,
  output logic [`NM_COUNT_W-1:0]  match_count
);

  ctx_state_e              ctx_state;

  // Saved DFA state per stream, valid only once a stream has been seen
  logic [`NM_STATE_W-1:0]  ctx_mem [2**`NM_STREAM_W];

  logic [`NM_STATE_W-1:0]  cur_state;
  logic                    match_flag;
  logic [`NM_STATE_W-1:0]  dfa_next;
  logic                    dfa_accept;
  logic                    fire;
  logic                    hit;

  sig_dfa sig_dfa_inst
  (
    .state_in  (cur_state),
    .char_in   (beat_in.data),
    .state_out (dfa_next),
    .accept    (dfa_accept)
  );

  // Load cycle holds the sop beat at the head while the context is read
  assign beat_in.ready = (ctx_state == CTX_SCAN);
  assign fire          = beat_in.valid && beat_in.ready;
  // Packet result including the current byte
  assign hit           = match_flag || dfa_accept;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ctx_state   <= CTX_IDLE;
      pkt_done    <= 1'b0;
      match_count <= '0;
    end
    else
    begin
      pkt_done <= 1'b0;
      case (ctx_state)
        CTX_IDLE:
          ctx_state <= CTX_LOAD;
        CTX_LOAD:
          // Only a sop beat can sit at the head here
          if (beat_in.valid)
            ctx_state <= CTX_SCAN;
        CTX_SCAN:
          if (fire && beat_in.eop)
          begin
            ctx_state <= CTX_LOAD;
            pkt_done  <= 1'b1;
            if (beat_in.enable)
              match_count <= match_count + `NM_COUNT_W'(hit);
          end
        default:
          ctx_state <= CTX_IDLE;
      endcase
    end
  end

  // DFA state, speculative flag and result payload
  always_ff @(posedge clk)
  begin
    if (ctx_state == CTX_LOAD && beat_in.valid)
    begin
      // New stream starts from scratch, otherwise resume
      cur_state  <= beat_in.new_stream ? '0 : ctx_mem[beat_in.stream_id];
      match_flag <= 1'b0;
    end
    else if (fire)
    begin
      cur_state  <= dfa_next;
      match_flag <= hit;
    end
    if (fire && beat_in.eop)
    begin
      pkt_matched   <= hit;
      pkt_stream_id <= beat_in.stream_id;
    end
  end

  // Context save, disabled packets leave the stream untouched
  always_ff @(posedge clk)
  begin
    if (fire && beat_in.eop && beat_in.enable)
      ctx_mem[beat_in.stream_id] <= dfa_next;
  end

endmodule

/* hdl/stream_ingress.sv */
`include "nids_match_consts.svh"

module stream_ingress
  import nids_match_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  logic [7:0]              in_data,
  input  logic                    in_sop,
  input  logic                    in_eop,
  input  logic [`NM_STREAM_W-1:0] in_stream_id,
  input  logic                    in_new_stream,
  input  logic                    in_enable,
  output logic                    in_ready,
  pkt_beat_if.producer            beat_out,
  output logic                    framing_error
);

  frame_state_e            frame_state;

  // Header latched from the sop beat
  logic [`NM_STREAM_W-1:0] hdr_stream_id;
  logic                    hdr_new_stream;
  logic                    hdr_enable;

  logic                    frame_ok;
  logic                    drop;
  logic                    fire;

  // Sop only with no open packet, other bytes only inside one
  assign frame_ok = in_sop ? (frame_state == FR_IDLE) : (frame_state == FR_IN_PKT);
  assign drop     = in_valid && !frame_ok;
  assign fire     = beat_out.valid && beat_out.ready;

  // Illegal beats are swallowed here, legal ones see the FIFO's ready
  assign in_ready = drop ? 1'b1 : beat_out.ready;

  // Pass-through, header comes straight from the inputs on sop
  assign beat_out.valid      = in_valid && frame_ok;
  assign beat_out.data       = in_data;
  assign beat_out.sop        = in_sop;
  assign beat_out.eop        = in_eop;
  assign beat_out.stream_id  = in_sop ? in_stream_id  : hdr_stream_id;
  assign beat_out.new_stream = in_sop ? in_new_stream : hdr_new_stream;
  assign beat_out.enable     = in_sop ? in_enable     : hdr_enable;

  // Framing state and sticky error
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      frame_state   <= FR_IDLE;
      framing_error <= 1'b0;
    end
    else
    begin
      if (drop)
        framing_error <= 1'b1;
      // A sop with eop is a one-byte packet and leaves the state idle
      if (fire && in_eop)
        frame_state <= FR_IDLE;
      else if (fire && in_sop)
        frame_state <= FR_IN_PKT;
    end
  end

  // Header capture on an accepted sop
  always_ff @(posedge clk)
  begin
    if (fire && in_sop)
    begin
      hdr_stream_id  <= in_stream_id;
      hdr_new_stream <= in_new_stream;
      hdr_enable     <= in_enable;
    end
  end

endmodule

/* verification/nids_match_checker.sv */
`include "nids_match_consts.svh"

module nids_match_checker
(
  input logic                    clk,
  input logic                    rst_n,
  input logic                    in_valid,
  input logic                    in_ready,
  input logic [7:0]              in_data,
  input logic                    in_sop,
  input logic                    in_eop,
  input logic [`NM_STREAM_W-1:0] in_stream_id,
  input logic                    in_new_stream,
  input logic                    in_enable,
  input logic                    pkt_done,
  input logic                    framing_error,
  input logic [`NM_COUNT_W-1:0]  match_count
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of assertion failures so far
  int fail_count = 0;

  // A stalled input beat keeps valid and its payload until the transfer
  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid &&
      $stable({in_data, in_sop, in_eop, in_stream_id, in_new_stream, in_enable}))
    else
    begin
      fail_count++;
      $error("input beat changed while stalled");
    end

  // Result strobe lasts one cycle
  // Packets are at least two cycles apart
  done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    pkt_done |=> !pkt_done)
    else
    begin
      fail_count++;
      $error("pkt_done held longer than one cycle");
    end

  // Outputs come out of reset quiet with the count cleared
  reset_values: assert property (@(posedge clk)
    !rst_n |=> !pkt_done && !framing_error && (match_count == '0) && in_ready)
    else
    begin
      fail_count++;
      $error("outputs not at reset values after reset");
    end

endmodule

/* verification/nids_match_tb.sv */
`include "nids_match_consts.svh"

module nids_match_tb;

  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [7:0] byte_q_t [$];

  // Cycles any single wait may take
  localparam int WAIT_LIMIT = 1000;

  logic                    clk;
  logic                    rst_n;
  logic                    in_valid;
  logic [7:0]              in_data;
  logic                    in_sop;
  logic                    in_eop;
  logic [`NM_STREAM_W-1:0] in_stream_id;
  logic                    in_new_stream;
  logic                    in_enable;
  logic                    in_ready;
  logic                    pkt_done;
  logic                    pkt_matched;
  logic [`NM_STREAM_W-1:0] pkt_stream_id;
  logic [`NM_COUNT_W-1:0]  match_count;
  logic                    framing_error;

  // Reference model with saved DFA state per stream and a valid bit for it
  int                      model_state [2**`NM_STREAM_W];
  logic                    ctx_valid [2**`NM_STREAM_W];
  logic [`NM_COUNT_W-1:0]  model_count;
  logic                    exp_framing;
  logic [7:0]              sig [`NM_SIG_LEN];
  // Expected results in packet order
  logic [`NM_STREAM_W-1:0] exp_id_q [$];
  logic                    exp_m_q [$];

  int                      errors;
  int                      checks;
  int                      test_base;
  // Checker assertion failures already counted
  int                      assert_seen;
  logic                    hung;

  nids_match_top nids_match_top_inst
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_data       (in_data),
    .in_sop        (in_sop),
    .in_eop        (in_eop),
    .in_stream_id  (in_stream_id),
    .in_new_stream (in_new_stream),
    .in_enable     (in_enable),
    .in_ready      (in_ready),
    .pkt_done      (pkt_done),
    .pkt_matched   (pkt_matched),
    .pkt_stream_id (pkt_stream_id),
    .match_count   (match_count),
    .framing_error (framing_error)
  );

  bind nids_match_top nids_match_checker nids_match_checker_inst
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_data       (in_data),
    .in_sop        (in_sop),
    .in_eop        (in_eop),
    .in_stream_id  (in_stream_id),
    .in_new_stream (in_new_stream),
    .in_enable     (in_enable),
    .pkt_done      (pkt_done),
    .framing_error (framing_error),
    .match_count   (match_count)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // One DFA step for a literal that does not overlap itself
  function automatic int dfa_step(input int st, input logic [7:0] ch, output logic acc);
    acc = 1'b0;
    if (ch == sig[st])
    begin
      if (st == `NM_SIG_LEN - 1)
      begin
        acc = 1'b1;
        return 0;
      end
      return st + 1;
    end
    else if (ch == sig[0])
      return 1;
    else
      return 0;
  endfunction

  // Mostly signature letters so matches happen and straddle packets
  function automatic logic [7:0] rand_byte();
    if ($urandom_range(99) < 70)
      return sig[$urandom_range(`NM_SIG_LEN - 1)];
    else
      return 8'($urandom_range(255));
  endfunction

  function automatic byte_q_t str_bytes(input string s);
    byte_q_t q;
    for (int i = 0; i < s.len(); i++)
      q.push_back(s[i]);
    return q;
  endfunction

  task automatic check_pkt(input logic [`NM_STREAM_W-1:0] exp_id, input logic exp_m);
    checks++;
    if (pkt_stream_id !== exp_id || pkt_matched !== exp_m)
    begin
      errors++;
      $display("MISMATCH at %0t: result stream %0d matched %0b, expected stream %0d matched %0b",
               $time, pkt_stream_id, pkt_matched, exp_id, exp_m);
    end
  endtask

  task automatic check_count(input logic [`NM_COUNT_W-1:0] exp_count);
    checks++;
    if (match_count !== exp_count)
    begin
      errors++;
      $display("MISMATCH at %0t: match_count %0d, expected %0d", $time, match_count, exp_count);
    end
  endtask

  task automatic check_framing(input logic exp_err);
    checks++;
    if (framing_error !== exp_err)
    begin
      errors++;
      $display("MISMATCH at %0t: framing_error %0b, expected %0b", $time, framing_error, exp_err);
    end
  endtask

  // Registered outputs are settled by the falling edge
  always @(negedge clk)
  begin
    if (rst_n && pkt_done)
    begin
      if (exp_id_q.size() == 0)
      begin
        errors++;
        $display("Error at %0t: packet result with no packet outstanding", $time);
      end
      else
        check_pkt(exp_id_q.pop_front(), exp_m_q.pop_front());
    end
  end

  // Starts 1 ns after a rising edge and returns at the same phase after the transfer
  task automatic drive_beat(input logic [7:0] data, input logic sop, input logic eop,
                            input logic [`NM_STREAM_W-1:0] sid, input logic new_s,
                            input logic en);
    int n;
    if (hung)
      return;
    in_valid      = 1'b1;
    in_data       = data;
    in_sop        = sop;
    in_eop        = eop;
    in_stream_id  = sid;
    in_new_stream = new_s;
    in_enable     = en;
    n = 0;
    // Ready is stable from the drive point to the next rising edge
    forever
    begin
      @(negedge clk);
      if (in_ready)
        break;
      n++;
      if (n == WAIT_LIMIT)
      begin
        hung = 1'b1;
        $display("Error at %0t: input beat was never accepted", $time);
        break;
      end
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // Sends one packet and runs it through the model
  // stray_at places a dropped sop before that byte
  task automatic send_packet(input logic [`NM_STREAM_W-1:0] sid, input logic new_s,
                             input logic en, input byte_q_t bytes, input int stray_at);
    int   st;
    logic acc;
    logic m;
    logic ns;
    // A stream with no saved context has to start fresh
    ns = new_s || !ctx_valid[sid];
    st = ns ? 0 : model_state[sid];
    m  = 1'b0;
    foreach (bytes[i])
    begin
      if (i == stray_at)
        drive_beat(rand_byte(), 1'b1, 1'b0, sid, 1'b1, 1'b1);
      // Later beats carry random header inputs that the framer must ignore
      if (i == 0)
        drive_beat(bytes[i], 1'b1, bytes.size() == 1, sid, ns, en);
      else
        drive_beat(bytes[i], 1'b0, i == bytes.size() - 1, `NM_STREAM_W'($urandom),
                   1'($urandom), 1'($urandom));
      st = dfa_step(st, bytes[i], acc);
      m  = m | acc;
    end
    // Disabled packets report but leave context and count alone
    if (en)
    begin
      model_state[sid] = st;
      ctx_valid[sid]   = 1'b1;
      model_count      = model_count + `NM_COUNT_W'(m);
    end
    exp_id_q.push_back(sid);
    exp_m_q.push_back(m);
  endtask

  // Waits for all outstanding results and then compares count and framing
  task automatic settle();
    int n;
    n = 0;
    while (exp_id_q.size() != 0 && !hung)
    begin
      @(posedge clk);
      n++;
      if (n == WAIT_LIMIT)
      begin
        hung = 1'b1;
        $display("Error at %0t: packet results stopped arriving", $time);
      end
    end
    @(negedge clk);
    check_count(model_count);
    check_framing(exp_framing);
    @(posedge clk);
    #1;
  endtask

  task automatic finish_test(input string name);
    errors      = errors + (nids_match_top_inst.nids_match_checker_inst.fail_count - assert_seen);
    assert_seen = nids_match_top_inst.nids_match_checker_inst.fail_count;
    $display("Test %-30s %s, %0d errors", name, (errors == test_base) ? "ok" : "FAILED",
             errors - test_base);
    test_base = errors;
  endtask

  initial
  begin
    byte_q_t q;
    int      len;
    void'($urandom(32'ha59864f2));
    sig[0] = `NM_SIG_0;
    sig[1] = `NM_SIG_1;
    sig[2] = `NM_SIG_2;
    sig[3] = `NM_SIG_3;
    sig[4] = `NM_SIG_4;
    for (int i = 0; i < 2**`NM_STREAM_W; i++)
    begin
      model_state[i] = 0;
      ctx_valid[i]   = 1'b0;
    end
    model_count   = '0;
    exp_framing   = 1'b0;
    errors        = 0;
    checks        = 0;
    test_base     = 0;
    assert_seen   = 0;
    hung          = 1'b0;
    rst_n         = 1'b0;
    in_valid      = 1'b0;
    in_data       = '0;
    in_sop        = 1'b0;
    in_eop        = 1'b0;
    in_stream_id  = '0;
    in_new_stream = 1'b0;
    in_enable     = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    send_packet(6'd0, 1'b1, 1'b1, str_bytes("abGROUPz"), -1);
    settle();
    finish_test("single packet detection");

    // Split across packets and the same split broken by new_stream
    send_packet(6'd1, 1'b1, 1'b1, str_bytes("xGRO"), -1);
    send_packet(6'd1, 1'b0, 1'b1, str_bytes("UPx"), -1);
    send_packet(6'd2, 1'b1, 1'b1, str_bytes("GRO"), -1);
    send_packet(6'd2, 1'b1, 1'b1, str_bytes("UP"), -1);
    settle();
    finish_test("cross packet context");

    // Saved state stays at two across the disabled packet
    send_packet(6'd3, 1'b1, 1'b1, str_bytes("ZGR"), -1);
    send_packet(6'd3, 1'b0, 1'b0, str_bytes("GROUP"), -1);
    send_packet(6'd3, 1'b0, 1'b1, str_bytes("OUP"), -1);
    settle();
    finish_test("enable semantics");

    // Back-to-back packets outrun the matcher and fill the FIFO
    repeat (400)
    begin
      q.delete();
      len = $urandom_range(12, 1);
      repeat (len) q.push_back(rand_byte());
      send_packet(6'($urandom_range(3)), $urandom_range(9) == 0, $urandom_range(3) != 0, q, -1);
      if ($urandom_range(2) == 0)
        idle_cycles($urandom_range(4, 1));
    end
    settle();
    finish_test("random interleaved traffic");

    // Byte with no open packet and a sop inside a packet
    drive_beat(8'h47, 1'b0, 1'b0, 6'd0, 1'b0, 1'b1);
    exp_framing = 1'b1;
    send_packet(6'd0, 1'b0, 1'b1, str_bytes("GROUPGR"), 3);
    send_packet(6'd0, 1'b0, 1'b1, str_bytes("OUP"), -1);
    send_packet(6'd2, 1'b0, 1'b1, str_bytes("xGROUP"), 1);
    settle();
    finish_test("framing errors");

    $display("Summary: %0d checks, %0d errors, timeout %0b", checks, errors, hung);
    if (errors == 0 && !hung)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule
